/* verilog.f */
cpu_pkg.sv
instr_sequencer.sv
program_memory.sv
datapath.sv
cpu_top.sv
cpu_top_sva.sv
cpu_top_tb.sv

/* Makefile */
# Verilator simulation of the accumulator CPU testbench

VERILATOR ?= verilator
TOP       ?= cpu_top_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "TEST PASS" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* cpu_top_tb.sv */
/*
 * Testbench for the accumulator CPU
 * Loads random programs through the load port, runs each one to HALT
 * and compares every reported store with an instruction-set model
 * working on its own copy of memory
 */
`timescale 1ns/1ps

module cpu_top_tb;
    import cpu_pkg::*;

    localparam int MEM_WORDS       = 256;
    localparam int CLK_PERIOD      = 10;
    localparam int RESET_CYCLES    = 8;
    localparam int NUM_PROGRAMS    = 24;
    localparam int MAX_INSTR       = 24;
    localparam int HALT_HOLD       = 6;     // Cycles watched after halt
    localparam int PROG_CYCLES     = RESET_CYCLES + MEM_WORDS + 3 * (MAX_INSTR + 1)
                                     + HALT_HOLD + 4;
    localparam int WATCHDOG_CYCLES = NUM_PROGRAMS * PROG_CYCLES + 200;

    logic  clk;
    logic  ireg_reset;
    logic  run;
    logic  load_en;
    addr_t load_addr;
    data_t load_data;
    logic  store_valid;
    addr_t store_addr;
    data_t store_data;
    logic  halt;

    data_t image [MEM_WORDS];               // Memory contents of the current program
    addr_t exp_addr_q [$];
    data_t exp_data_q [$];
    int    store_count;
    int    model_stores;
    int    jz_taken;

    cpu_top #(
        .MEM_WORDS (MEM_WORDS)
    ) cpu_top_i (
        .clk         (clk),
        .ireg_reset  (ireg_reset),
        .run         (run),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .store_valid (store_valid),
        .store_addr  (store_addr),
        .store_data  (store_data),
        .halt        (halt)
    );

    bind cpu_top cpu_top_sva cpu_top_sva_i (
        .clk         (clk),
        .ireg_reset  (ireg_reset),
        .run         (run),
        .halt        (halt),
        .store_valid (store_valid),
        .mem_write   (mem_write),
        .pc_write    (pc_write),
        .a_load      (a_load),
        .b_load      (b_load),
        .mreg_load   (mreg_load)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Error at %0t ns: %s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Error at %0t ns: %s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("Error at %0t ns: %s got %b expected %b",
                                     $time, name, got, exp));
        end
    endtask

    function automatic bit has_operand(input opcode_e op);
        case (op)
            LDAI, LDA, STA, LDBI, STB, JMP, JZ: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic opcode_e pick_opcode();
        case ($urandom_range(0, 13))
            0:       return NOP;
            1:       return LDAI;
            2:       return LDA;
            3:       return STA;
            4:       return LDBI;
            5:       return STB;
            6:       return ADD;
            7:       return SUB;
            8:       return AND;
            9:       return XOR;
            10:      return JMP;
            11:      return JZ;
            12:      return MOV_AB;
            default: return MOV_BA;
        endcase
    endfunction

    // Random code in the lower half, data addresses in the upper half
    task automatic build_program();
        opcode_e ops [$];
        data_t   args [$];
        int      starts [$];
        addr_t   pool [$];
        data_t   fill_key;
        opcode_e op;
        data_t   imm;
        int      n;
        int      offset;

        fill_key = data_t'($urandom);
        for (int a = 0; a < MEM_WORDS; a++) begin
            image[addr_t'(a)] = data_t'(a) ^ fill_key;
        end
        for (int k = 0; k < 4; k++) begin
            pool.push_back(addr_t'(MEM_WORDS / 2 + $urandom_range(0, MEM_WORDS / 2 - 1)));
        end
        n = $urandom_range(8, MAX_INSTR);
        for (int i = 0; i < n; i++) begin
            op = pick_opcode();
            case (op)
                LDAI, LDBI: begin
                    if ($urandom_range(0, 1) == 1) begin
                        imm = data_t'($urandom_range(0, 3));   // Makes zero results likely
                    end else begin
                        imm = data_t'($urandom);
                    end
                end
                LDA, STA, STB: imm = pool[$urandom_range(0, 3)];
                default:       imm = '0;
            endcase
            ops.push_back(op);
            args.push_back(imm);
        end
        ops.push_back(HALT);
        args.push_back('0);
        offset = 0;
        for (int i = 0; i <= n; i++) begin
            starts.push_back(offset);
            offset += has_operand(ops[i]) ? 2 : 1;
        end
        for (int i = 0; i < n; i++) begin
            if (ops[i] == JMP || ops[i] == JZ) begin
                args[i] = data_t'(starts[$urandom_range(i + 1, n)]);  // Forward only
            end
            image[addr_t'(starts[i])] = data_t'(ops[i]);
            if (has_operand(ops[i])) begin
                image[addr_t'(starts[i] + 1)] = args[i];
            end
        end
        image[addr_t'(starts[n])] = data_t'(HALT);
    endtask

    // Instruction-set model, fills the expected store queues
    function automatic int run_model();
        data_t   mem [MEM_WORDS];
        addr_t   pc;
        data_t   a;
        data_t   b;
        data_t   arg;
        logic    z;
        opcode_e op;
        int      count;
        bit      done;

        mem   = image;
        pc    = '0;
        a     = '0;
        b     = '0;
        z     = 1'b0;
        count = 0;
        done  = 1'b0;
        exp_addr_q.delete();
        exp_data_q.delete();
        while (!done) begin
            op = opcode_e'(mem[pc]);
            pc = pc + addr_t'(1);
            count++;
            arg = '0;
            if (has_operand(op)) begin
                arg = mem[pc];
                pc  = pc + addr_t'(1);
            end
            case (op)
                NOP:    ;
                LDAI:   a = arg;
                LDBI:   b = arg;
                LDA:    a = mem[arg];
                STA, STB: begin
                    mem[arg] = (op == STA) ? a : b;
                    exp_addr_q.push_back(arg);
                    exp_data_q.push_back(mem[arg]);
                end
                ADD:    a = a + b;
                SUB:    a = a - b;
                AND:    a = a & b;
                XOR:    a = a ^ b;
                JMP:    pc = arg;
                JZ: begin
                    if (z) begin
                        pc = arg;
                        jz_taken++;
                    end
                end
                MOV_AB: b = a;
                MOV_BA: a = b;
                default: done = 1'b1;       // HALT and unknown codes
            endcase
            if (op inside {ADD, SUB, AND, XOR}) begin
                z = (a == '0);
            end
        end
        model_stores = exp_addr_q.size();
        return count;
    endfunction

    task automatic apply_reset();
        @(negedge clk);
        ireg_reset = 1'b1;
        run        = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        ireg_reset = 1'b0;
    endtask

    task automatic load_image();
        for (int a = 0; a < MEM_WORDS; a++) begin
            @(negedge clk);
            check_level("halt", halt, 1'b0);
            check_level("store_valid", store_valid, 1'b0);
            load_en   = 1'b1;
            load_addr = addr_t'(a);
            load_data = image[addr_t'(a)];
        end
        @(negedge clk);
        load_en = 1'b0;
    endtask

    task automatic wait_for_halt(input int limit);
        int cycles;

        cycles = 0;
        while (halt !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                report_failure($sformatf("CPU did not halt within %0d cycles", limit));
            end
        end
    endtask

    // Compares each reported store with the next one of the model
    always @(posedge clk) begin
        if (!ireg_reset && store_valid) begin
            if (exp_addr_q.size() == 0) begin
                report_failure($sformatf("Unexpected store to %h at %0t ns",
                                         store_addr, $time));
            end else begin
                check_addr("store_addr", store_addr, exp_addr_q.pop_front());
                check_data("store_data", store_data, exp_data_q.pop_front());
                store_count++;
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        report_failure($sformatf("Watchdog expired after %0d cycles", WATCHDOG_CYCLES));
    end

    initial begin
        int instr_count;
        int total_instr;
        int sva_errors;

        void'($urandom(32'h46f6));
        clk          = 1'b0;
        ireg_reset   = 1'b1;
        run          = 1'b0;
        load_en      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        store_count  = 0;
        model_stores = 0;
        jz_taken     = 0;
        total_instr  = 0;

        for (int p = 0; p < NUM_PROGRAMS; p++) begin
            apply_reset();
            build_program();
            instr_count = run_model();
            total_instr += instr_count;
            store_count = 0;
            load_image();
            run = 1'b1;
            wait_for_halt(3 * instr_count + 4);
            repeat (HALT_HOLD) begin
                @(negedge clk);
                check_level("halt", halt, 1'b1);
            end
            if (store_count != model_stores) begin
                report_failure($sformatf("Error at %0t ns: store count got %0d expected %0d",
                                         $time, store_count, model_stores));
            end
        end

        sva_errors = cpu_top_i.cpu_top_sva_i.assert_errors;
        $display("Ran %0d programs, %0d instructions, %0d taken JZ",
                 NUM_PROGRAMS, total_instr, jz_taken);
        if (sva_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("%0d assertion failures reported", sva_errors);
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* cpu_top_sva.sv */
/*
 * Bound checks for the accumulator CPU
 * Halt holds until reset, a halted CPU issues no strobes and reports
 * no store, a store pulse lasts one cycle, and reset clears the halt
 * and store outputs
 */
`timescale 1ns/1ps

module cpu_top_sva (
    input logic clk,
    input logic ireg_reset,
    input logic run,
    input logic halt,
    input logic store_valid,
    input logic mem_write,
    input logic pc_write,
    input logic a_load,
    input logic b_load,
    input logic mreg_load
);
    int assert_errors = 0;                  // Assertion failures so far

    halt_sticky: assert property (@(posedge clk) disable iff (ireg_reset)
        halt |=> halt)
        else begin
            assert_errors++;
            $error("halt dropped without a reset");
        end

    halt_quiet: assert property (@(posedge clk) disable iff (ireg_reset)
        halt |-> !(mem_write || pc_write || a_load || b_load || mreg_load))
        else begin
            assert_errors++;
            $error("Strobe active while halted");
        end

    store_pulse: assert property (@(posedge clk) disable iff (ireg_reset)
        store_valid |=> !store_valid)
        else begin
            assert_errors++;
            $error("store_valid held for more than one cycle");
        end

    store_not_halted: assert property (@(posedge clk) disable iff (ireg_reset)
        halt |-> !store_valid)
        else begin
            assert_errors++;
            $error("store_valid reported while halted");
        end

    write_needs_run: assert property (@(posedge clk) disable iff (ireg_reset)
        mem_write |-> run)
        else begin
            assert_errors++;
            $error("Memory write while run is low");
        end

    reset_clears: assert property (@(posedge clk)
        ireg_reset |=> !halt && !store_valid)
        else begin
            assert_errors++;
            $error("halt or store_valid high after reset");
        end

endmodule

/* cpu_top.sv */
/*
 * Accumulator CPU top level
 * Connects the instruction sequencer, the program memory and the
 * datapath. Programs enter through the load port while run is low.
 */
`timescale 1ns/1ps

module cpu_top #(
    parameter int MEM_WORDS = 256
) (
    input  logic           clk,
    input  logic           ireg_reset,
    input  logic           run,
    input  logic           load_en,
    input  cpu_pkg::addr_t load_addr,
    input  cpu_pkg::data_t load_data,
    output logic           store_valid,
    output cpu_pkg::addr_t store_addr,
    output cpu_pkg::data_t store_data,
    output logic           halt
);
    import cpu_pkg::*;

    // Control strobes from the sequencer
    logic    a_load;
    logic    b_load;
    logic    a_out;
    logic    b_out;
    logic    alu_out;
    logic    mem_read_pc;
    logic    mem_read_mreg;
    logic    mem_write;
    logic    mreg_load;
    logic    pc_inc;
    logic    pc_write;
    alu_op_e alu_op;

    data_t   mem_rdata;
    data_t   bus_data;
    logic    zero_flag;

    instr_sequencer instr_sequencer_i (
        .clk           (clk),
        .ireg_reset    (ireg_reset),
        .run           (run),
        .mem_rdata     (mem_rdata),
        .zero_flag     (zero_flag),
        .a_load        (a_load),
        .b_load        (b_load),
        .a_out         (a_out),
        .b_out         (b_out),
        .alu_out       (alu_out),
        .mem_read_pc   (mem_read_pc),
        .mem_read_mreg (mem_read_mreg),
        .mem_write     (mem_write),
        .mreg_load     (mreg_load),
        .pc_inc        (pc_inc),
        .pc_write      (pc_write),
        .alu_op        (alu_op),
        .halt          (halt)
    );

    program_memory #(
        .MEM_WORDS (MEM_WORDS)
    ) program_memory_i (
        .clk           (clk),
        .ireg_reset    (ireg_reset),
        .run           (run),
        .load_en       (load_en),
        .load_addr     (load_addr),
        .load_data     (load_data),
        .mem_read_pc   (mem_read_pc),
        .mem_read_mreg (mem_read_mreg),
        .mem_write     (mem_write),
        .mreg_load     (mreg_load),
        .pc_inc        (pc_inc),
        .pc_write      (pc_write),
        .bus_data      (bus_data),
        .mem_rdata     (mem_rdata),
        .store_valid   (store_valid),
        .store_addr    (store_addr),
        .store_data    (store_data)
    );

    datapath datapath_i (
        .clk        (clk),
        .ireg_reset (ireg_reset),
        .mem_rdata  (mem_rdata),
        .a_load     (a_load),
        .b_load     (b_load),
        .a_out      (a_out),
        .b_out      (b_out),
        .alu_out    (alu_out),
        .alu_op     (alu_op),
        .bus_data   (bus_data),
        .zero_flag  (zero_flag)
    );

endmodule

/* datapath.sv */
/*
 * Datapath
 * A and B registers on a shared internal bus, the ALU and the zero
 * flag. The bus falls back to memory data when no register or the
 * ALU drives it.
 */
`timescale 1ns/1ps

module datapath (
    input  logic             clk,
    input  logic             ireg_reset,
    input  cpu_pkg::data_t   mem_rdata,
    input  logic             a_load,
    input  logic             b_load,
    input  logic             a_out,
    input  logic             b_out,
    input  logic             alu_out,
    input  cpu_pkg::alu_op_e alu_op,
    output cpu_pkg::data_t   bus_data,
    output logic             zero_flag
);
    import cpu_pkg::*;

    data_t a_reg;
    data_t b_reg;
    data_t alu_result;

    always_comb begin
        case (alu_op)
            ALU_ADD: alu_result = a_reg + b_reg;    // Wraps modulo 256
            ALU_SUB: alu_result = a_reg - b_reg;
            ALU_AND: alu_result = a_reg & b_reg;
            ALU_XOR: alu_result = a_reg ^ b_reg;
        endcase
    end

    // Internal bus source select
    always_comb begin
        if (a_out) begin
            bus_data = a_reg;
        end else if (b_out) begin
            bus_data = b_reg;
        end else if (alu_out) begin
            bus_data = alu_result;
        end else begin
            bus_data = mem_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (ireg_reset) begin
            a_reg     <= '0;
            b_reg     <= '0;
            zero_flag <= 1'b0;
        end else begin
            if (a_load) begin
                a_reg <= bus_data;
            end
            if (b_load) begin
                b_reg <= bus_data;
            end
            if (a_load && alu_out) begin
                zero_flag <= (alu_result == '0);    // Only ALU results count
            end
        end
    end

endmodule

/* program_memory.sv */
/*
 * Program memory
 * Byte array shared by code and data, with the program counter and
 * the address register. Accepts load port writes while stopped and
 * reports every CPU store as a one-cycle pulse.
 */
`timescale 1ns/1ps

module program_memory #(
    parameter int MEM_WORDS = 256
) (
    input  logic           clk,
    input  logic           ireg_reset,
    input  logic           run,
    input  logic           load_en,
    input  cpu_pkg::addr_t load_addr,
    input  cpu_pkg::data_t load_data,
    input  logic           mem_read_pc,
    input  logic           mem_read_mreg,
    input  logic           mem_write,
    input  logic           mreg_load,
    input  logic           pc_inc,
    input  logic           pc_write,
    input  cpu_pkg::data_t bus_data,
    output cpu_pkg::data_t mem_rdata,
    output logic           store_valid,
    output cpu_pkg::addr_t store_addr,
    output cpu_pkg::data_t store_data
);
    import cpu_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);

    data_t            mem [MEM_WORDS];
    addr_t            pc;
    addr_t            mreg;
    logic [IDX_W-1:0] pc_idx;
    logic [IDX_W-1:0] mreg_idx;
    logic [IDX_W-1:0] load_idx;

    // Addresses wrap modulo the depth
    assign pc_idx   = pc[IDX_W-1:0];
    assign mreg_idx = mreg[IDX_W-1:0];
    assign load_idx = load_addr[IDX_W-1:0];

    always_comb begin
        if (mem_read_pc) begin
            mem_rdata = mem[pc_idx];
        end else if (mem_read_mreg) begin
            mem_rdata = mem[mreg_idx];
        end else begin
            mem_rdata = '0;                     // No read this stage
        end
    end

    always_ff @(posedge clk) begin
        if (ireg_reset) begin
            pc          <= '0;
            mreg        <= '0;
            store_valid <= 1'b0;
        end else begin
            if (pc_write) begin
                pc <= mreg;                     // Jump target
            end else if (pc_inc) begin
                pc <= pc + addr_t'(1);
            end
            if (mreg_load) begin
                mreg <= mem_rdata;
            end
            store_valid <= mem_write;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_write) begin
            mem[mreg_idx] <= bus_data;
            store_addr    <= mreg;
            store_data    <= bus_data;
        end else if (load_en && !run) begin
            mem[load_idx] <= load_data;         // Program load while stopped
        end
    end

endmodule

/* instr_sequencer.sv */
/*
 * Instruction sequencer
 * Holds the instruction register and a stage counter, and decodes
 * the control strobes of each stage from the opcode. The last stage
 * of every instruction fetches the next opcode and restarts the count.
 */
`timescale 1ns/1ps

module instr_sequencer (
    input  logic             clk,
    input  logic             ireg_reset,
    input  logic             run,
    input  cpu_pkg::data_t   mem_rdata,
    input  logic             zero_flag,
    output logic             a_load,
    output logic             b_load,
    output logic             a_out,
    output logic             b_out,
    output logic             alu_out,
    output logic             mem_read_pc,
    output logic             mem_read_mreg,
    output logic             mem_write,
    output logic             mreg_load,
    output logic             pc_inc,
    output logic             pc_write,
    output cpu_pkg::alu_op_e alu_op,
    output logic             halt
);
    import cpu_pkg::*;

    opcode_e    ireg;
    logic [1:0] stage;
    logic       stage_restart;              // Fetch stage of the current opcode

    always_ff @(posedge clk) begin
        if (ireg_reset) begin
            ireg  <= NOP;                   // First stage fetches address 0
            stage <= 2'd0;
        end else if (stage_restart) begin
            ireg  <= opcode_e'(mem_rdata);
            stage <= 2'd0;
        end else if (run && !halt) begin
            stage <= stage + 2'd1;
        end
    end

    always_comb begin
        a_load        = 1'b0;
        b_load        = 1'b0;
        a_out         = 1'b0;
        b_out         = 1'b0;
        alu_out       = 1'b0;
        mem_read_pc   = 1'b0;
        mem_read_mreg = 1'b0;
        mem_write     = 1'b0;
        mreg_load     = 1'b0;
        pc_inc        = 1'b0;
        pc_write      = 1'b0;
        stage_restart = 1'b0;
        alu_op        = ALU_ADD;
        halt          = 1'b0;

        case (ireg)
            NOP: stage_restart = 1'b1;
            HALT: halt = 1'b1;
            LDAI, LDBI: begin
                if (stage == 2'd0) begin
                    a_load      = (ireg == LDAI);   // Immediate byte onto the bus
                    b_load      = (ireg == LDBI);
                    mem_read_pc = 1'b1;
                    pc_inc      = 1'b1;
                end else begin
                    stage_restart = 1'b1;
                end
            end
            LDA, STA, STB: begin
                if (stage == 2'd0) begin
                    mreg_load   = 1'b1;             // Address byte
                    mem_read_pc = 1'b1;
                    pc_inc      = 1'b1;
                end else if (stage == 2'd1) begin
                    a_load        = (ireg == LDA);
                    mem_read_mreg = (ireg == LDA);
                    a_out         = (ireg == STA);
                    b_out         = (ireg == STB);
                    mem_write     = (ireg != LDA);
                end else begin
                    stage_restart = 1'b1;
                end
            end
            ADD, SUB, AND, XOR: begin
                case (ireg)
                    SUB:     alu_op = ALU_SUB;
                    AND:     alu_op = ALU_AND;
                    XOR:     alu_op = ALU_XOR;
                    default: alu_op = ALU_ADD;
                endcase
                if (stage == 2'd0) begin
                    a_load  = 1'b1;                 // Result back into A
                    alu_out = 1'b1;
                end else begin
                    stage_restart = 1'b1;
                end
            end
            JMP, JZ: begin
                if (stage == 2'd0) begin
                    mreg_load   = 1'b1;             // Target always read
                    mem_read_pc = 1'b1;
                    pc_inc      = 1'b1;
                end else if (stage == 2'd1) begin
                    pc_write = (ireg == JMP) || zero_flag;
                end else begin
                    stage_restart = 1'b1;
                end
            end
            MOV_AB, MOV_BA: begin
                if (stage == 2'd0) begin
                    a_out  = (ireg == MOV_AB);
                    b_load = (ireg == MOV_AB);
                    b_out  = (ireg == MOV_BA);
                    a_load = (ireg == MOV_BA);
                end else begin
                    stage_restart = 1'b1;
                end
            end
            default: halt = 1'b1;               // Unknown opcode
        endcase

        // Stalled CPU issues nothing
        if (!run) begin
            a_load        = 1'b0;
            b_load        = 1'b0;
            a_out         = 1'b0;
            b_out         = 1'b0;
            alu_out       = 1'b0;
            mem_read_mreg = 1'b0;
            mem_write     = 1'b0;
            mreg_load     = 1'b0;
            mem_read_pc   = 1'b0;
            pc_inc        = 1'b0;
            pc_write      = 1'b0;
            stage_restart = 1'b0;
        end

        if (stage_restart) begin
            mem_read_pc = 1'b1;                 // Opcode at PC into ireg
            pc_inc      = 1'b1;
        end
    end

endmodule

/* cpu_pkg.sv */
/*
 * CPU package
 * Shared data and address widths, the opcode encodings of the
 * accumulator instruction set and the ALU function select used
 * between the sequencer and the datapath
 */
package cpu_pkg;

    localparam int DATA_W = 8;              // One data word
    localparam int ADDR_W = 8;              // Single address byte

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // Instruction byte, any unlisted value halts the CPU
    typedef enum logic [7:0] {
        NOP    = 8'h00,
        HALT   = 8'h01,
        LDAI   = 8'h02,                     // A <= imm
        LDA    = 8'h03,                     // A <= mem[addr]
        STA    = 8'h04,                     // mem[addr] <= A
        LDBI   = 8'h05,                     // B <= imm
        STB    = 8'h06,                     // mem[addr] <= B
        ADD    = 8'h07,
        SUB    = 8'h08,
        AND    = 8'h09,
        XOR    = 8'h0A,
        JMP    = 8'h0B,                     // PC <= addr
        JZ     = 8'h0C,                     // PC <= addr if zero flag
        MOV_AB = 8'h0D,                     // B <= A
        MOV_BA = 8'h0E                      // A <= B
    } opcode_e;

    // ALU function, decoded from the opcode in the load stage
    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_AND = 2'd2,
        ALU_XOR = 2'd3
    } alu_op_e;

endpackage
